// File: Bender.yml
package:
  name: wb_mem_subsys

sources:
  # Shared package
  - common/soc_pkg.sv

  # RTL
  - source/wb_addr_decode.sv
  - wb_ram_slave/wb_ram_slave.sv
  - source/wb_resp_mux.sv
  - source/wb_bus_monitor.sv
  - source/wb_mem_subsys.sv

  # Testbench
  - target: test
    files:
      - tests/tb_wb_mem_subsys.sv

// File: common/soc_pkg.sv
package soc_pkg;

   ////////////////////////////////////////////////////////////
   // Master bus geometry
   ////////////////////////////////////////////////////////////

   // Byte address seen on the master port
   localparam int ADDR_W = 32;

   // One word of data
   localparam int DATA_W = 64;

   // Width of a single byte lane
   localparam int BYTE_W = 8;

   // One select bit per byte lane, bit k enables data byte k
   localparam int SEL_W = DATA_W / BYTE_W;

   // Byte offset inside a word, not used for addressing
   localparam int WORD_LSB = 3;

   ////////////////////////////////////////////////////////////
   // Bus monitor
   ////////////////////////////////////////////////////////////

   // Each transfer counter wraps around when it overflows
   localparam int CNT_W = 16;

endpackage

// File: source/wb_addr_decode.sv
`timescale 1ns/1ps

module wb_addr_decode #(
   parameter  int NUM_SLAVES = 4,
   parameter  int SLAVE_AW   = 6,
   localparam int IDX_W      = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
)(
   input  logic                       wb_clk_i,
   input  logic                       wb_rst_i,
   input  logic [soc_pkg::ADDR_W-1:0] wb_adr_i,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   output logic [NUM_SLAVES-1:0]      slv_stb_o,
   output logic [IDX_W-1:0]           slv_idx_o,
   output logic                       dec_err_o
);

   // Slave index sits right above the word offset
   localparam int IDX_LSB = soc_pkg::WORD_LSB + SLAVE_AW;
   localparam int HI_LSB  = IDX_LSB + IDX_W;

   logic req;
   logic hi_set;
   logic unmapped;

   assign req = wb_cyc_i && wb_stb_i;

   ////////////////////////////////////////////////////////////
   // Address split
   ////////////////////////////////////////////////////////////

   assign slv_idx_o = wb_adr_i[IDX_LSB +: IDX_W];

   // Anything above the index field lies outside the map
   assign hi_set   = |wb_adr_i[soc_pkg::ADDR_W-1:HI_LSB];
   assign unmapped = hi_set || (slv_idx_o >= NUM_SLAVES);

   // One strobe per slave, only for a live mapped request
   always_comb
   begin
      slv_stb_o = '0;
      if (req && !unmapped)
         slv_stb_o[slv_idx_o] = 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // Error reply for unmapped addresses
   ////////////////////////////////////////////////////////////

   // Same one-cycle pulse rule as the RAM acknowledge
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         dec_err_o <= 1'b0;
      else
         dec_err_o <= req && unmapped && !dec_err_o;
   end

   // Error reply and a slave transfer must not overlap
   a_err_no_stb: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i)
      dec_err_o |-> !(|slv_stb_o)
   );

endmodule

// File: source/wb_bus_monitor.sv
`timescale 1ns/1ps

module wb_bus_monitor (
   input  logic                      wb_clk_i,
   input  logic                      wb_rst_i,
   input  logic                      wb_we_i,
   input  logic                      wb_ack_i,
   input  logic                      wb_err_i,
   output logic [soc_pkg::CNT_W-1:0] rd_count_o,
   output logic [soc_pkg::CNT_W-1:0] wr_count_o,
   output logic [soc_pkg::CNT_W-1:0] err_count_o
);

   ////////////////////////////////////////////////////////////
   // Transfer counters
   ////////////////////////////////////////////////////////////

   // Completed reads
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         rd_count_o <= '0;
      else if (wb_ack_i && !wb_we_i)
         rd_count_o <= rd_count_o + 1'b1;
   end

   // Completed writes
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         wr_count_o <= '0;
      else if (wb_ack_i && wb_we_i)
         wr_count_o <= wr_count_o + 1'b1;
   end

   // Error replies, direction does not matter
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         err_count_o <= '0;
      else if (wb_err_i)
         err_count_o <= err_count_o + 1'b1;
   end

endmodule

// File: source/wb_mem_subsys.sv
`timescale 1ns/1ps

module wb_mem_subsys #(
   parameter int NUM_SLAVES = 4,
   parameter int SLAVE_AW   = 6
)(
   input  logic                       wb_clk_i,
   input  logic                       wb_rst_i,

   // Master port
   input  logic [soc_pkg::ADDR_W-1:0] wb_adr_i,
   input  logic [soc_pkg::DATA_W-1:0] wb_dat_i,
   input  logic [soc_pkg::SEL_W-1:0]  wb_sel_i,
   input  logic                       wb_we_i,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   output logic [soc_pkg::DATA_W-1:0] wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,

   // Monitor counts
   output logic [soc_pkg::CNT_W-1:0]  rd_count_o,
   output logic [soc_pkg::CNT_W-1:0]  wr_count_o,
   output logic [soc_pkg::CNT_W-1:0]  err_count_o
);

   localparam int IDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

   logic [NUM_SLAVES-1:0]                 slv_stb;
   logic [NUM_SLAVES-1:0]                 slv_ack;
   logic [NUM_SLAVES*soc_pkg::DATA_W-1:0] slv_dat;
   logic [IDX_W-1:0]                      slv_idx;
   logic                                  dec_err;

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////

   wb_addr_decode #(
      .NUM_SLAVES (NUM_SLAVES),
      .SLAVE_AW   (SLAVE_AW)
   ) u_decode (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .wb_adr_i  (wb_adr_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_stb_i  (wb_stb_i),
      .slv_stb_o (slv_stb),
      .slv_idx_o (slv_idx),
      .dec_err_o (dec_err)
   );

   ////////////////////////////////////////////////////////////
   // RAM slaves
   ////////////////////////////////////////////////////////////

   // Word offset, data, select and we go to every slave
   for (genvar s = 0; s < NUM_SLAVES; s++)
   begin : g_slave
      wb_ram_slave #(
         .SLAVE_AW (SLAVE_AW)
      ) u_ram (
         .wb_clk_i (wb_clk_i),
         .wb_rst_i (wb_rst_i),
         .wb_adr_i (wb_adr_i[soc_pkg::WORD_LSB +: SLAVE_AW]),
         .wb_dat_i (wb_dat_i),
         .wb_sel_i (wb_sel_i),
         .wb_we_i  (wb_we_i),
         .wb_stb_i (slv_stb[s]),
         .wb_dat_o (slv_dat[s*soc_pkg::DATA_W +: soc_pkg::DATA_W]),
         .wb_ack_o (slv_ack[s])
      );
   end

   ////////////////////////////////////////////////////////////
   // Reply path and monitor
   ////////////////////////////////////////////////////////////

   wb_resp_mux #(
      .NUM_SLAVES (NUM_SLAVES)
   ) u_resp_mux (
      .slv_ack_i (slv_ack),
      .slv_dat_i (slv_dat),
      .slv_idx_i (slv_idx),
      .dec_err_i (dec_err),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .wb_err_o  (wb_err_o)
   );

   wb_bus_monitor u_monitor (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wb_we_i     (wb_we_i),
      .wb_ack_i    (wb_ack_o),
      .wb_err_i    (wb_err_o),
      .rd_count_o  (rd_count_o),
      .wr_count_o  (wr_count_o),
      .err_count_o (err_count_o)
   );

endmodule

// File: source/wb_resp_mux.sv
`timescale 1ns/1ps

module wb_resp_mux #(
   parameter  int NUM_SLAVES = 4,
   localparam int IDX_W      = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
)(
   input  logic [NUM_SLAVES-1:0]                 slv_ack_i,
   input  logic [NUM_SLAVES*soc_pkg::DATA_W-1:0] slv_dat_i,
   input  logic [IDX_W-1:0]                      slv_idx_i,
   input  logic                                  dec_err_i,
   output logic [soc_pkg::DATA_W-1:0]            wb_dat_o,
   output logic                                  wb_ack_o,
   output logic                                  wb_err_o
);

   ////////////////////////////////////////////////////////////
   // Reply merge
   ////////////////////////////////////////////////////////////

   // Only the addressed slave can be acknowledging
   assign wb_ack_o = |slv_ack_i;

   // Decoder owns the error reply
   assign wb_err_o = dec_err_i;

   // Read data of the addressed slave, zero when idle
   always_comb
   begin
      wb_dat_o = '0;
      if (wb_ack_o && (slv_idx_i < NUM_SLAVES))
         wb_dat_o = slv_dat_i[slv_idx_i*soc_pkg::DATA_W +: soc_pkg::DATA_W];
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // No clock here, so the checks are resolved at end of time step
   a_ack_onehot: assert final ($onehot0(slv_ack_i))
      else $error("more than one slave acknowledging");

   a_ack_err_excl: assert final (!(wb_ack_o && wb_err_o))
      else $error("ack and err driven together");

endmodule

// File: src.f
common/soc_pkg.sv
source/wb_addr_decode.sv
wb_ram_slave/wb_ram_slave.sv
source/wb_resp_mux.sv
source/wb_bus_monitor.sv
source/wb_mem_subsys.sv
tests/tb_wb_mem_subsys.sv

// File: tests/tb_wb_mem_subsys.sv
`timescale 1ns/1ps

module tb_wb_mem_subsys;

   localparam int NUM_SLAVES = 4;
   localparam int SLAVE_AW   = 6;
   localparam int IDX_W      = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
   localparam int DEPTH      = 1 << SLAVE_AW;
   localparam int IDX_LSB    = soc_pkg::WORD_LSB + SLAVE_AW;
   localparam int HI_LSB     = IDX_LSB + IDX_W;
   localparam int CLK_PERIOD = 40;
   localparam int N_RAND     = 32;
   localparam int N_UNMAP    = 8;

   // Fill, readback, random pairs, shared offset pairs, unmapped, final readback
   localparam int N_XFER = 3 * NUM_SLAVES * DEPTH + 2 * N_RAND + 2 * NUM_SLAVES + N_UNMAP;
   localparam int WATCHDOG_NS = (N_XFER * 3 + 100) * CLK_PERIOD;

   logic                       wb_clk_i = 1'b0;
   logic                       wb_rst_i;
   logic [soc_pkg::ADDR_W-1:0] wb_adr_i;
   logic [soc_pkg::DATA_W-1:0] wb_dat_i;
   logic [soc_pkg::SEL_W-1:0]  wb_sel_i;
   logic                       wb_we_i;
   logic                       wb_cyc_i;
   logic                       wb_stb_i;
   logic [soc_pkg::DATA_W-1:0] wb_dat_o;
   logic                       wb_ack_o;
   logic                       wb_err_o;
   logic [soc_pkg::CNT_W-1:0]  rd_count_o;
   logic [soc_pkg::CNT_W-1:0]  wr_count_o;
   logic [soc_pkg::CNT_W-1:0]  err_count_o;

   // Reference copy of all slaves, indexed by slave and word offset
   logic [soc_pkg::DATA_W-1:0] ref_mem [0:NUM_SLAVES*DEPTH-1];

   logic [soc_pkg::DATA_W-1:0] exp_dat = '0;
   bit                         exp_err = 1'b0;
   bit                         count_chk = 1'b0;
   // Strobe stays high through the reply, next transfer follows directly
   bit                         keep_stb = 1'b0;
   int                         errors = 0;
   int                         n_rd = 0;
   int                         n_wr = 0;
   int                         n_err = 0;
   integer                     seed = 32'hc2c8b612;

   wb_mem_subsys UUT (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_we_i     (wb_we_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .wb_err_o    (wb_err_o),
      .rd_count_o  (rd_count_o),
      .wr_count_o  (wr_count_o),
      .err_count_o (err_count_o)
   );

   always #(CLK_PERIOD/2) wb_clk_i = ~wb_clk_i;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic report_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
      errors++;
      $display("ERROR %s expected %h actual %h at %0t", name, exp_v, got_v, $time);
   endtask

   task automatic report_event(input string what);
      errors++;
      $display("Check failed: %s at %0t", what, $time);
   endtask

   // Byte k of the new word replaces byte k of the old one when sel[k] is set
   function automatic logic [63:0] lane_merge(input logic [63:0] old_w,
                                              input logic [63:0] new_w,
                                              input logic [7:0] sel);
      logic [63:0] res;
      res = old_w;
      for (int k = 0; k < soc_pkg::SEL_W; k++)
         if (sel[k])
            res[k*8 +: 8] = new_w[k*8 +: 8];
      return res;
   endfunction

   function automatic bit addr_mapped(input logic [31:0] adr);
      logic [31:0] hi;
      int          idx;
      hi  = adr >> HI_LSB;
      idx = int'(adr[IDX_LSB +: IDX_W]);
      return (hi == 0) && (idx < NUM_SLAVES);
   endfunction

   function automatic logic [31:0] word_adr(input int slv, input int ofs);
      return (32'(slv) << IDX_LSB) | (32'(ofs) << soc_pkg::WORD_LSB);
   endfunction

   // One classic cycle, held until ack or err shows up
   task automatic bus_xfer(input logic [31:0] adr, input logic we,
                           input logic [63:0] dat, input logic [7:0] sel);
      bit mapped;
      int loc;
      mapped = addr_mapped(adr);
      loc    = int'(adr[IDX_LSB +: IDX_W]) * DEPTH + int'(adr[soc_pkg::WORD_LSB +: SLAVE_AW]);
      @(negedge wb_clk_i);
      exp_err  = !mapped;
      exp_dat  = mapped ? ref_mem[loc] : '0;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      do
         @(negedge wb_clk_i);
      while (!(wb_ack_o || wb_err_o));
      // Address and we stay put through the reply cycle
      if (!keep_stb)
      begin
         wb_cyc_i = 1'b0;
         wb_stb_i = 1'b0;
      end
      if (!mapped)
         n_err++;
      else if (we)
      begin
         n_wr++;
         ref_mem[loc] = lane_merge(ref_mem[loc], dat, sel);
      end
      else
         n_rd++;
   endtask

   task automatic read_all();
      for (int s = 0; s < NUM_SLAVES; s++)
         for (int o = 0; o < DEPTH; o++)
            bus_xfer(word_adr(s, o), 1'b0, '0, '0);
   endtask

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   a_reset_ack: assert property (@(posedge wb_clk_i) wb_rst_i |-> !wb_ack_o)
      else report_value("wb_ack_o", 0, $sampled(wb_ack_o));
   a_reset_err: assert property (@(posedge wb_clk_i) wb_rst_i |-> !wb_err_o)
      else report_value("wb_err_o", 0, $sampled(wb_err_o));

   a_reply_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o) |=> (wb_ack_o || wb_err_o))
      else report_event("no reply one cycle after the strobe was sampled");

   a_reply_requested: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i))
      else report_event("reply without a strobe in the cycle before");

   a_reply_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o))
      else report_event("reply held longer than one cycle");

   a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(wb_ack_o && wb_err_o))
      else report_event("ack and err high in the same cycle");

   // Mapped address expects ack, unmapped expects err
   a_reply_kind: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_ack_o || wb_err_o) |-> (wb_err_o == exp_err))
      else report_value("wb_err_o", exp_err, $sampled(wb_err_o));

   a_read_data: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_ack_o && !wb_we_i) |-> (wb_dat_o == exp_dat))
      else report_value("wb_dat_o", exp_dat, $sampled(wb_dat_o));

   a_rd_count: assert property (@(posedge wb_clk_i)
      count_chk |-> (rd_count_o == n_rd[soc_pkg::CNT_W-1:0]))
      else report_value("rd_count_o", n_rd[soc_pkg::CNT_W-1:0], $sampled(rd_count_o));
   a_wr_count: assert property (@(posedge wb_clk_i)
      count_chk |-> (wr_count_o == n_wr[soc_pkg::CNT_W-1:0]))
      else report_value("wr_count_o", n_wr[soc_pkg::CNT_W-1:0], $sampled(wr_count_o));
   a_err_count: assert property (@(posedge wb_clk_i)
      count_chk |-> (err_count_o == n_err[soc_pkg::CNT_W-1:0]))
      else report_value("err_count_o", n_err[soc_pkg::CNT_W-1:0], $sampled(err_count_o));

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      logic [31:0] rnd;
      logic [31:0] adr;
      logic [63:0] dat;
      int          s;
      int          o;
      wb_rst_i = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      repeat (5) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;

      // Full-select fill, pattern built from the whole address
      for (int i = 0; i < NUM_SLAVES; i++)
         for (int j = 0; j < DEPTH; j++)
         begin
            adr = word_adr(i, j);
            bus_xfer(adr, 1'b1, {~adr, adr ^ 32'h5a5a_5a5a}, '1);
         end
      read_all();

      // Random partial selects, low byte-offset bits scrambled too
      for (int i = 0; i < N_RAND; i++)
      begin
         rnd = $random(seed);
         s   = rnd % NUM_SLAVES;
         rnd = $random(seed);
         o   = rnd % DEPTH;
         dat = {$random(seed), $random(seed)};
         rnd = $random(seed);
         adr = word_adr(s, o) | rnd[10:8];
         // Write and read-back run back to back with the strobe held
         keep_stb = 1'b1;
         bus_xfer(adr, 1'b1, dat, rnd[7:0]);
         keep_stb = 1'b0;
         bus_xfer(adr, 1'b0, '0, '0);
      end

      // Same offset in every slave, each with its own value
      for (int i = 0; i < NUM_SLAVES; i++)
      begin
         dat = {$random(seed), $random(seed)};
         dat[63:56] = 8'(i);
         bus_xfer(word_adr(i, DEPTH - 3), 1'b1, dat, '1);
      end
      for (int i = 0; i < NUM_SLAVES; i++)
         bus_xfer(word_adr(i, DEPTH - 3), 1'b0, '0, '0);

      // Unmapped reads and writes
      for (int i = 0; i < N_UNMAP; i++)
      begin
         rnd = $random(seed);
         case (i % 4)
            0: adr = 32'h8000_0000 | rnd[7:0];
            1: adr = 32'(NUM_SLAVES) << IDX_LSB;
            2: adr = 32'(1) << (HI_LSB + 3);
            default: adr = rnd | 32'h8000_0000;
         endcase
         bus_xfer(adr, (i >= 4), {$random(seed), $random(seed)}, rnd[15:8]);
      end
      read_all();

      @(negedge wb_clk_i);
      count_chk = 1'b1;
      @(negedge wb_clk_i);
      count_chk = 1'b0;

      $display("Done: %0d errors, %0d reads, %0d writes, %0d unmapped",
               errors, n_rd, n_wr, n_err);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: test did not finish within %0d ns", WATCHDOG_NS);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// File: wb_ram_slave/wb_ram_slave.sv
`timescale 1ns/1ps

module wb_ram_slave #(
   parameter int SLAVE_AW = 6
)(
   input  logic                       wb_clk_i,
   input  logic                       wb_rst_i,
   input  logic [SLAVE_AW-1:0]        wb_adr_i,
   input  logic [soc_pkg::DATA_W-1:0] wb_dat_i,
   input  logic [soc_pkg::SEL_W-1:0]  wb_sel_i,
   input  logic                       wb_we_i,
   input  logic                       wb_stb_i,
   output logic [soc_pkg::DATA_W-1:0] wb_dat_o,
   output logic                       wb_ack_o
);

   localparam int DEPTH = 1 << SLAVE_AW;

   // Word storage, contents survive reset
   logic [soc_pkg::DATA_W-1:0] mem [0:DEPTH-1];

   // Transfer accepted at this edge
   logic take;

   assign take = wb_stb_i && !wb_ack_o;

   ////////////////////////////////////////////////////////////
   // Acknowledge
   ////////////////////////////////////////////////////////////

   // Single-cycle pulse, low again before the next transfer
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= take;
   end

   ////////////////////////////////////////////////////////////
   // Storage access
   ////////////////////////////////////////////////////////////

   // Byte-lane write, unselected lanes keep their value
   always_ff @(posedge wb_clk_i)
   begin
      if (take && wb_we_i)
      begin
         for (int k = 0; k < soc_pkg::SEL_W; k++)
         begin
            if (wb_sel_i[k])
               mem[wb_adr_i][k*soc_pkg::BYTE_W +: soc_pkg::BYTE_W] <=
                  wb_dat_i[k*soc_pkg::BYTE_W +: soc_pkg::BYTE_W];
         end
      end
   end

   // Read word lands together with the ack
   always_ff @(posedge wb_clk_i)
   begin
      if (take && !wb_we_i)
         wb_dat_o <= mem[wb_adr_i];
   end

endmodule
